/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := snn_stream_tb
FILELIST := snn_stream.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the simulation passes only if the pass line shows up in its output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

/* bench/snn_stream_assert.sv */
/*
 * concurrent assertions bound to the stream processor top level
 * reset state, sink hold rule, no output without an accepted run packet
 */

`timescale 1ns/1ps

module snn_stream_assert (
    input logic clk,
    input logic arstn,
    input logic src_valid,
    input logic src_ready,
    input logic [snn_pkg::PKT_IN_WIDTH-1:0] src,
    input logic snk_valid,
    input logic snk_ready,
    input logic [snn_pkg::PKT_OUT_WIDTH-1:0] snk
);
    import snn_pkg::*;

    // failure counts, one per property
    int fail_reset = 0;
    int fail_hold = 0;
    int fail_early = 0;
    int fail_count;

    // accepted run packets against transferred outputs
    int runs_in;
    int runs_out;
    logic run_flag;

    assign fail_count = fail_reset + fail_hold + fail_early;
    assign run_flag = src[PKT_IN_WIDTH - 1 - int'(FLG_RUN)];

    always_ff @(posedge clk or negedge arstn) begin: count_runs
        if (arstn == 1'b0) begin
            runs_in <= 0;
            runs_out <= 0;
        end else begin
            if (src_valid && src_ready && run_flag) begin
                runs_in <= runs_in + 1;
            end
            if (snk_valid && snk_ready) begin
                runs_out <= runs_out + 1;
            end
        end
    end

    // no output and an open input while reset is held
    reset_idle: assert property (@(posedge clk) !arstn |-> (!snk_valid && src_ready))
        else begin
            $error("outputs not idle during reset");
            fail_reset++;
        end

    // a stalled output packet must not move or change
    hold_stable: assert property (@(posedge clk) disable iff (!arstn)
        (snk_valid && !snk_ready) |=> (snk_valid && $stable(snk)))
        else begin
            $error("output packet changed or dropped while stalled");
            fail_hold++;
        end

    // every output needs a run packet that has not been answered yet
    no_early_output: assert property (@(posedge clk) disable iff (!arstn)
        snk_valid |-> (runs_in > runs_out))
        else begin
            $error("output valid without an outstanding run packet");
            fail_early++;
        end

endmodule

/* bench/snn_stream_tb.sv */
/*
 * testbench for the spiking stream processor
 * clock, reset, directed and random packets, reference model
 * output comparison, per-test lines and closing counts
 */

`timescale 1ns/1ps

`include "snn_defines.svh"

module snn_stream_tb;
    import snn_pkg::*;

    logic clk;
    logic arstn;
    logic src_valid;
    logic src_ready;
    logic [PKT_IN_WIDTH-1:0] src;
    logic snk_valid;
    logic snk_ready;
    logic [PKT_OUT_WIDTH-1:0] snk;

    int seed;
    int errors;
    int tests;
    int failed;
    int accept_cnt;
    logic ready_random;
    // written only by the clock counter and the output monitor
    int cycle_cnt = 0;
    int rx_count = 0;
    int out_errors = 0;

    // reference model: potentials, pending flags, expected outputs in order
    int pot [`SNN_NUM_OUT];
    logic pend_sync;
    logic pend_clr;
    logic [PKT_OUT_WIDTH-1:0] exp_q [$];

    snn_stream snn_stream_i (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src_ready(src_ready),
        .src(src),
        .snk_valid(snk_valid),
        .snk_ready(snk_ready),
        .snk(snk)
    );

    bind snn_stream snn_stream_assert snn_stream_assert_i (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src_ready(src_ready),
        .src(src),
        .snk_valid(snk_valid),
        .snk_ready(snk_ready),
        .snk(snk)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // flags at the top, spike i at bit width - 4 - i
    function automatic logic [PKT_IN_WIDTH-1:0] build_input(
        input logic run, input logic sync, input logic clr, input inp_spk_t spk);
        logic [PKT_IN_WIDTH-1:0] pkt;
        pkt = '0;
        pkt[PKT_IN_WIDTH-1] = run;
        pkt[PKT_IN_WIDTH-2] = sync;
        pkt[PKT_IN_WIDTH-3] = clr;
        for (int i = 0; i < `SNN_NUM_INP; i++) begin
            pkt[PKT_IN_WIDTH-4-i] = spk[i];
        end
        return pkt;
    endfunction

    // just after the next rising edge, with a new random ready if enabled
    task automatic next_cycle();
        int rnd;
        @(posedge clk);
        #1;
        if (ready_random) begin
            rnd = $random(seed);
            snk_ready = rnd[0];
        end
    endtask

    // one accepted packet: clear, integrate, fire, queue the expected output
    task automatic apply_model(input logic [PKT_IN_WIDTH-1:0] pkt);
        int sum;
        logic [PKT_OUT_WIDTH-1:0] want;
        pend_sync = pend_sync | pkt[PKT_IN_WIDTH-2];
        pend_clr = pend_clr | pkt[PKT_IN_WIDTH-3];
        if (pkt[PKT_IN_WIDTH-3]) begin
            for (int j = 0; j < `SNN_NUM_OUT; j++) begin
                pot[j] = 0;
            end
        end
        if (pkt[PKT_IN_WIDTH-1]) begin
            want = '0;
            want[PKT_OUT_WIDTH-2] = pend_sync;
            want[PKT_OUT_WIDTH-3] = pend_clr;
            for (int j = 0; j < `SNN_NUM_OUT; j++) begin
                // neuron j adds spikes j and j + 4
                sum = pot[j] + int'(pkt[PKT_IN_WIDTH-4-j])
                    + int'(pkt[PKT_IN_WIDTH-4-j-`SNN_NUM_OUT]);
                if (sum >= `SNN_THRESHOLD) begin
                    want[PKT_OUT_WIDTH-4-j] = 1'b1;
                    pot[j] = 0;
                end else begin
                    pot[j] = sum;
                end
            end
            exp_q.push_back(want);
            pend_sync = 1'b0;
            pend_clr = 1'b0;
        end
    endtask

    task automatic send_packet(input logic [PKT_IN_WIDTH-1:0] pkt);
        int waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        src = pkt;
        src_valid = 1'b1;
        while (!taken && waited < 100) begin
            @(negedge clk);
            taken = src_ready;
            accept_cnt = cycle_cnt;
            next_cycle();
            waited++;
        end
        src_valid = 1'b0;
        if (taken) begin
            apply_model(pkt);
        end else begin
            $display("timeout at %0t: src_ready stayed low for %0d cycles", $time, waited);
            errors++;
        end
    endtask

    // all expected outputs received and nothing left valid
    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((rx_count < exp_q.size() || snk_valid) && waited < 300) begin
            next_cycle();
            waited++;
        end
        if (rx_count < exp_q.size() || snk_valid) begin
            $display("timeout at %0t: output packets still outstanding", $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        int err_now;
        err_now = errors + out_errors;
        tests++;
        if (err_now == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed, %0d errors", tests, name, err_now - err_before);
        end
    endtask

    // compare each transferred packet, sampled mid-cycle
    always @(negedge clk) begin: check_output
        if (arstn && snk_valid && snk_ready) begin
            assert (rx_count < exp_q.size()) else begin
                $display("output packet %b at %0t arrived with no run packet pending",
                    snk, $time);
                out_errors++;
            end
            if (rx_count < exp_q.size()) begin
                assert (snk === exp_q[rx_count]) else begin
                    $display("MISMATCH at %0t: output %0d is %b, expected %b",
                        $time, rx_count, snk, exp_q[rx_count]);
                    out_errors++;
                end
            end
            rx_count++;
        end
    end

    initial begin: run_tests
        int err_before;
        int rnd;
        int lat;
        seed = 1017;
        errors = 0;
        tests = 0;
        failed = 0;
        accept_cnt = 0;
        ready_random = 1'b0;
        pend_sync = 1'b0;
        pend_clr = 1'b0;
        for (int j = 0; j < `SNN_NUM_OUT; j++) begin
            pot[j] = 0;
        end
        arstn = 1'b0;
        src_valid = 1'b0;
        src = '0;
        snk_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        arstn = 1'b1;

        err_before = errors + out_errors;
        @(negedge clk);
        assert (!snk_valid) else begin
            $display("MISMATCH at %0t: snk_valid high after reset", $time);
            errors++;
        end
        assert (src_ready) else begin
            $display("MISMATCH at %0t: src_ready low after reset", $time);
            errors++;
        end
        next_cycle();
        finish_test("reset state", err_before);

        // neuron 0 gains 2 per step, neurons 1 and 2 gain 1, neuron 3 none
        err_before = errors + out_errors;
        repeat (6) send_packet(build_input(1'b1, 1'b0, 1'b0, 8'h17));
        wait_drained();
        finish_test("integrate and fire", err_before);

        err_before = errors + out_errors;
        send_packet(build_input(1'b1, 1'b0, 1'b0, 8'h22));
        send_packet(build_input(1'b0, 1'b0, 1'b1, 8'h00));
        send_packet(build_input(1'b1, 1'b0, 1'b0, 8'h03));
        wait_drained();
        finish_test("clear", err_before);

        err_before = errors + out_errors;
        send_packet(build_input(1'b0, 1'b1, 1'b0, 8'h00));
        // a sync alone must stay silent
        for (int k = 0; k < 6; k++) begin
            next_cycle();
            assert (!snk_valid) else begin
                $display("MISMATCH at %0t: output after a sync-only packet", $time);
                errors++;
            end
        end
        send_packet(build_input(1'b1, 1'b0, 1'b0, 8'h00));
        send_packet(build_input(1'b1, 1'b0, 1'b0, 8'h00));
        wait_drained();
        finish_test("sync", err_before);

        err_before = errors + out_errors;
        ready_random = 1'b1;
        for (int k = 0; k < 40; k++) begin
            rnd = $random(seed);
            send_packet(rnd[PKT_IN_WIDTH-1:0]);
        end
        wait_drained();
        ready_random = 1'b0;
        snk_ready = 1'b1;
        next_cycle();
        finish_test("back-pressure", err_before);

        err_before = errors + out_errors;
        send_packet(build_input(1'b1, 1'b0, 1'b0, 8'h01));
        lat = -1;
        for (int k = 0; k < 20 && lat < 0; k++) begin
            @(negedge clk);
            if (snk_valid) begin
                lat = cycle_cnt - accept_cnt;
            end
        end
        assert (lat == 2) else begin
            $display("MISMATCH at %0t: latency %0d cycles, expected 2", $time, lat);
            errors++;
        end
        next_cycle();
        wait_drained();
        finish_test("latency", err_before);

        errors = errors + out_errors + snn_stream_i.snn_stream_assert_i.fail_count;
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // overall limit in case a loop bound is never reached
    initial begin: watchdog
        #200000;
        $display("simulation time limit reached at %0t", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* logic/net_if.sv */
/*
 * network strobe bus between pipeline stages
 * run, sync and clear strobes, ready level, spike vector
 */

`timescale 1ns/1ps

interface net_if #(
    parameter int WIDTH = 8
);
    // one-cycle strobes from the producing stage
    logic run;
    logic sync;
    logic clear;
    // level from the consuming stage
    logic ready;
    // spikes, valid alongside run
    logic [WIDTH-1:0] spikes;

    modport upstream (output run, output sync, output clear, output spikes, input ready);

    modport downstream (input run, input sync, input clear, input spikes, output ready);

endinterface

/* logic/network_core.sv */
/*
 * single layer of integrate-and-fire neurons
 * per-neuron membrane potentials, fixed weights, no leak
 * output hold register stalls the layer under back-pressure
 */

`timescale 1ns/1ps

`include "snn_defines.svh"

module network_core (
    // global inputs
    input logic clk,
    input logic arstn,
    // strobes from the source
    net_if.downstream inp,
    // strobes towards the sink
    net_if.upstream out
);
    import snn_pkg::*;

    typedef logic [`SNN_POT_WIDTH-1:0] pot_t;

    // membrane potentials and their next values for a run step
    pot_t pot [`SNN_NUM_OUT];
    pot_t pot_nxt [`SNN_NUM_OUT];
    out_spk_t fire;

    // output hold register
    logic out_full;
    out_spk_t out_spk;
    logic out_take;

    // sync and clear, delayed one cycle
    logic sync_q;
    logic clear_q;

    assign out_take = out_full && out.ready;

    // a packet accepted now arrives as a strobe next cycle, so the hold
    // register must be free by then: empty or draining, and no result
    // of an earlier strobe landing in it at this edge
    assign inp.ready = (!out_full || out.ready) && !inp.run;

    // one run step: optional clear, integrate, threshold, reset on fire
    always_comb begin: integrate
        pot_t base;
        pot_t sum;
        for (int j = 0; j < `SNN_NUM_OUT; j++) begin
            // clear is applied before this step's spikes
            base = inp.clear ? '0 : pot[j];
            // neuron j sees spikes j and j + NUM_OUT with weight 1
            sum = base + pot_t'(inp.spikes[j]) + pot_t'(inp.spikes[j + `SNN_NUM_OUT]);
            fire[j] = (sum >= pot_t'(`SNN_THRESHOLD));
            pot_nxt[j] = fire[j] ? '0 : sum;
        end
    end

    // potentials move on a run strobe, a bare clear only zeroes them
    always_ff @(posedge clk or negedge arstn) begin: update_pot
        if (arstn == 1'b0) begin
            for (int j = 0; j < `SNN_NUM_OUT; j++) begin
                pot[j] <= '0;
            end
        end else if (inp.run) begin
            for (int j = 0; j < `SNN_NUM_OUT; j++) begin
                pot[j] <= pot_nxt[j];
            end
        end else if (inp.clear) begin
            for (int j = 0; j < `SNN_NUM_OUT; j++) begin
                pot[j] <= '0;
            end
        end
    end

    // result occupancy, a new result may replace one drained this cycle
    always_ff @(posedge clk or negedge arstn) begin: hold_run
        if (arstn == 1'b0) begin
            out_full <= 1'b0;
        end else if (inp.run) begin
            out_full <= 1'b1;
        end else if (out_take) begin
            out_full <= 1'b0;
        end
    end

    // spike vector of the held result
    always_ff @(posedge clk) begin: hold_spk
        if (inp.run) begin
            out_spk <= fire;
        end
    end

    // sync and clear are forwarded as pulses, never held here
    always_ff @(posedge clk or negedge arstn) begin: pass_flags
        if (arstn == 1'b0) begin
            sync_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            sync_q <= inp.sync;
            clear_q <= inp.clear;
        end
    end

    assign out.run = out_full;
    assign out.spikes = out_spk;
    assign out.sync = sync_q;
    assign out.clear = clear_q;

endmodule

/* logic/network_sink.sv */
/*
 * output stage of the stream processor
 * latches sync and clear until an output transfer
 * packs flag prefix and output spikes into the sink packet
 */

`timescale 1ns/1ps

module network_sink (
    // global inputs
    input logic clk,
    input logic arstn,
    // strobes from the core
    net_if.downstream net,
    // sink handshake
    input logic snk_ready,
    output logic snk_valid,
    // sink packet
    output logic [snn_pkg::PKT_OUT_WIDTH-1:0] snk
);
    import snn_pkg::*;

    logic take;
    // bit 0 holds a pending sync, bit 1 a pending clear
    logic [1:0] req_hold;

    // the core's result is valid as long as run is up
    assign snk_valid = net.run;
    // core drains its hold register only when the sink takes it
    assign net.ready = snk_ready;

    assign take = snk_valid && snk_ready;

    // a transfer consumes the requests, a pulse in that same cycle
    // already shows up in the packet being taken
    always_ff @(posedge clk or negedge arstn) begin: set_requests
        if (arstn == 1'b0) begin
            req_hold <= 2'b00;
        end else if (take) begin
            req_hold <= 2'b00;
        end else begin
            req_hold <= req_hold | {net.clear, net.sync};
        end
    end

    // prefix first, then spike i below it
    always_comb begin: calc_snk
        snk = '0;
        // run never appears in an output packet
        snk[PKT_OUT_WIDTH - 1 - int'(FLG_RUN)] = 1'b0;
        snk[PKT_OUT_WIDTH - 1 - int'(FLG_SNC)] = req_hold[0] || net.sync;
        snk[PKT_OUT_WIDTH - 1 - int'(FLG_CLR)] = req_hold[1] || net.clear;
        for (int i = 0; i < $bits(out_spk_t); i++) begin
            snk[PKT_OUT_WIDTH - NUM_FLG - 1 - i] = net.spikes[i];
        end
    end

endmodule

/* logic/network_source.sv */
/*
 * input stage of the stream processor
 * accepts ready/valid packets and issues one-cycle network strobes
 */

`timescale 1ns/1ps

module network_source (
    // global inputs
    input logic clk,
    input logic arstn,
    // source handshake
    input logic src_valid,
    output logic src_ready,
    // source packet
    input logic [snn_pkg::PKT_IN_WIDTH-1:0] src,
    // strobes towards the core
    net_if.upstream net
);
    import snn_pkg::*;

    logic accept;
    logic run_bit;
    logic sync_bit;
    logic clear_bit;
    inp_spk_t spk_field;

    // registered strobes and spikes
    logic run_q;
    logic sync_q;
    logic clear_q;
    inp_spk_t spk_q;

    // the core decides when a packet can be taken
    assign src_ready = net.ready;
    assign accept = src_valid && src_ready;

    // split the packet into prefix flags and spike field
    always_comb begin: decode
        run_bit = src[PKT_IN_WIDTH - 1 - int'(FLG_RUN)];
        sync_bit = src[PKT_IN_WIDTH - 1 - int'(FLG_SNC)];
        clear_bit = src[PKT_IN_WIDTH - 1 - int'(FLG_CLR)];
        // spike 0 sits right below the prefix
        for (int i = 0; i < $bits(inp_spk_t); i++) begin
            spk_field[i] = src[PKT_IN_WIDTH - NUM_FLG - 1 - i];
        end
    end

    // strobes last exactly one cycle after the accepting edge
    always_ff @(posedge clk or negedge arstn) begin: set_strobes
        if (arstn == 1'b0) begin
            run_q <= 1'b0;
            sync_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            run_q <= accept && run_bit;
            sync_q <= accept && sync_bit;
            clear_q <= accept && clear_bit;
        end
    end

    // spikes only matter together with run
    always_ff @(posedge clk) begin: set_spikes
        if (accept) begin
            spk_q <= spk_field;
        end
    end

    assign net.run = run_q;
    assign net.sync = sync_q;
    assign net.clear = clear_q;
    assign net.spikes = spk_q;

endmodule

/* logic/snn_defines.svh */
/*
 * network size macros for the spiking stream processor
 * input spike count, neuron count, potential width, firing threshold
 */

`ifndef SNN_DEFINES_SVH
`define SNN_DEFINES_SVH

// spikes per input packet
`define SNN_NUM_INP 8

// neurons in the single layer, one output spike each
`define SNN_NUM_OUT 4

// membrane potential register width
`define SNN_POT_WIDTH 4

// a neuron fires once its potential reaches this value
`define SNN_THRESHOLD 3

`endif

/* logic/snn_pkg.sv */
/*
 * shared types for the spiking stream processor
 * flag position enum, packet widths, spike vector types
 */

`include "snn_defines.svh"

package snn_pkg;

    // flag positions within the packet prefix, counted from the msb
    typedef enum logic [1:0] {
        FLG_RUN = 2'd0,
        FLG_SNC = 2'd1,
        FLG_CLR = 2'd2
    } flag_e;

    // prefix width, one bit per flag
    localparam int NUM_FLG = 3;

    // full packet widths: prefix followed by the spike field
    localparam int PKT_IN_WIDTH  = NUM_FLG + `SNN_NUM_INP;
    localparam int PKT_OUT_WIDTH = NUM_FLG + `SNN_NUM_OUT;

    // spike vectors, bit i is spike i
    typedef logic [`SNN_NUM_INP-1:0] inp_spk_t;
    typedef logic [`SNN_NUM_OUT-1:0] out_spk_t;

endpackage

/* logic/snn_stream.sv */
/*
 * top level of the spiking stream processor
 * source, integrate-and-fire core and sink as a three-stage pipeline
 */

`timescale 1ns/1ps

`include "snn_defines.svh"

module snn_stream (
    // global inputs
    input logic clk,
    input logic arstn,
    // input packet port
    input logic src_valid,
    output logic src_ready,
    input logic [snn_pkg::PKT_IN_WIDTH-1:0] src,
    // output packet port
    output logic snk_valid,
    input logic snk_ready,
    output logic [snn_pkg::PKT_OUT_WIDTH-1:0] snk
);

    // source to core, carries the input spikes
    net_if #(.WIDTH(`SNN_NUM_INP)) inp_bus ();

    // core to sink, carries the output spikes
    net_if #(.WIDTH(`SNN_NUM_OUT)) out_bus ();

    network_source network_source_i (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src_ready(src_ready),
        .src(src),
        .net(inp_bus.upstream)
    );

    network_core network_core_i (
        .clk(clk),
        .arstn(arstn),
        .inp(inp_bus.downstream),
        .out(out_bus.upstream)
    );

    network_sink network_sink_i (
        .clk(clk),
        .arstn(arstn),
        .net(out_bus.downstream),
        .snk_ready(snk_ready),
        .snk_valid(snk_valid),
        .snk(snk)
    );

endmodule

/* snn_stream.f */
+incdir+logic
logic/snn_pkg.sv
logic/net_if.sv
logic/network_source.sv
logic/network_core.sv
logic/network_sink.sv
logic/snn_stream.sv
bench/snn_stream_assert.sv
bench/snn_stream_tb.sv
